// File: Makefile
VERILATOR  ?= verilator
TOP        := quadc_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
FAIL_MSG   := Simulation finished: FAIL
PASS_MSG   := Simulation finished: PASS

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; echo "Simulator exit status $$?" >> $(LOG); cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/quadc_decode.sv
`timescale 1ns/1ns

module quadc_decode (
    input  logic                               adc0_clk,
    input  logic                               reset,
    input  logic                               enable,
    input  quadc_pkg::mode_t                   mode,
    input  logic [quadc_pkg::sample_width-1:0] adc0_data,
    input  logic [quadc_pkg::sample_width-1:0] adc1_data,
    input  logic [quadc_pkg::sample_width-1:0] adc2_data,
    input  logic [quadc_pkg::sample_width-1:0] adc3_data,
    input  logic                               sync_in,
    output logic                               dec_valid,
    output quadc_pkg::op_t                     dec_op,
    output logic [quadc_pkg::word_width-1:0]   dec_word,
    output logic                               dec_frame
);

    import quadc_pkg::*;

    logic [word_width-1:0] cap_word;
    logic                  cap_sync;
    logic                  cap_sync_prev;
    logic                  cap_en;
    mode_t                 cap_mode;

    lock_state_t           state;
    logic                  sync_edge;
    logic                  emit;
    op_t                   op_next;

    // ==================================================
    // Input capture
    // ==================================================

    always_ff @(posedge adc0_clk) begin
        cap_word <= {adc0_data, adc1_data, adc2_data, adc3_data};  // Channel 0 in top byte
        cap_mode <= mode;
        if (reset) begin
            cap_sync      <= 1'b0;
            cap_sync_prev <= 1'b0;
            cap_en        <= 1'b0;
        end else begin
            cap_sync      <= sync_in;
            cap_sync_prev <= cap_sync;                  // Previous captured sync
            cap_en        <= enable;
        end
    end

    assign sync_edge = cap_sync & ~cap_sync_prev;

    // Locked sets always go out, in hunt only the sync set does
    assign emit = cap_en & ((state == st_locked) | sync_edge);

    // ==================================================
    // Frame lock FSM
    // ==================================================

    always_ff @(posedge adc0_clk) begin
        if (reset) begin
            state     <= st_hunt;
            dec_valid <= 1'b0;
            dec_frame <= 1'b0;
        end else begin
            dec_valid <= emit;
            dec_frame <= emit & sync_edge;
            case (state)
                st_hunt: begin
                    if (cap_en && sync_edge)
                        state <= st_locked;
                end
                st_locked: begin
                    if (!cap_en)
                        state <= st_hunt;               // Lock lost on enable low
                end
                default: state <= st_hunt;
            endcase
        end
    end

    // Mode to opcode
    always_comb begin
        case (cap_mode)
            mode_twos: op_next = op_twos;
            mode_sum:  op_next = op_sum;
            default:   op_next = op_raw;                // Raw and reserved
        endcase
    end

    always_ff @(posedge adc0_clk) begin
        if (emit) begin
            dec_word <= cap_word;
            dec_op   <= op_next;
        end
    end

    // A frame flag only rides on an emitted set
    assert property (@(posedge adc0_clk) disable iff (reset)
        dec_frame |-> dec_valid);

    // Output resumes after a gap only through a new sync edge
    assert property (@(posedge adc0_clk) disable iff (reset)
        $rose(dec_valid) |-> dec_frame);

endmodule

// File: rtl/quadc_execute.sv
`timescale 1ns/1ns

module quadc_execute (
    input  logic                             adc0_clk,
    input  logic                             reset,
    input  logic                             dec_valid,
    input  quadc_pkg::op_t                   dec_op,
    input  logic [quadc_pkg::word_width-1:0] dec_word,
    input  logic                             dec_frame,
    output logic                             exe_valid,
    output logic [quadc_pkg::word_width-1:0] exe_word,
    output logic                             exe_frame
);

    import quadc_pkg::*;

    // Top bit of every byte set
    localparam logic [word_width-1:0] sign_flip =
        {num_channels{1'b1, {(sample_width-1){1'b0}}}};

    logic [word_width-1:0]       twos_word;
    logic signed [sum_width-1:0] lane_sum;
    logic [word_width-1:0]       sum_word;
    logic [word_width-1:0]       result_word;

    // ==================================================
    // Transforms
    // ==================================================

    assign twos_word = dec_word ^ sign_flip;            // Offset binary to two's complement

    always_comb begin
        logic signed [sample_width-1:0] lane;

        lane_sum = '0;
        for (int ch = 0; ch < num_channels; ch++) begin
            lane     = twos_word[ch*sample_width +: sample_width];
            lane_sum = lane_sum + lane;                 // Lane sign extends here
        end
    end

    assign sum_word = {{(word_width-sum_width){lane_sum[sum_width-1]}}, lane_sum};

    always_comb begin
        case (dec_op)
            op_twos: result_word = twos_word;
            op_sum:  result_word = sum_word;
            default: result_word = dec_word;
        endcase
    end

    // ==================================================
    // Output register
    // ==================================================

    always_ff @(posedge adc0_clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
            exe_frame <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
            exe_frame <= dec_frame;
        end
    end

    always_ff @(posedge adc0_clk) begin
        if (dec_valid)
            exe_word <= result_word;
    end

    // Decode never hands over an opcode outside the enum
    assert property (@(posedge adc0_clk) disable iff (reset)
        dec_valid |-> !$isunknown(dec_op) && (dec_op inside {op_raw, op_twos, op_sum}));

endmodule

// File: rtl/quadc_pkg.sv
package quadc_pkg;

    // ==================================================
    // Sample geometry
    // ==================================================

    localparam int sample_width = 8;                            // Bits per ADC channel
    localparam int num_channels = 4;
    localparam int word_width   = sample_width * num_channels;  // Channel 0 in top byte
    localparam int sum_width    = 10;                           // Range -512 .. +508

    // ==================================================
    // Host mode and execute operations
    // ==================================================

    typedef enum logic [1:0] {
        mode_raw      = 2'd0,
        mode_twos     = 2'd1,
        mode_sum      = 2'd2,
        mode_reserved = 2'd3                                    // Treated as raw
    } mode_t;

    typedef enum logic [1:0] {
        op_raw  = 2'd0,                                         // Word passes unchanged
        op_twos = 2'd1,                                         // Offset binary to signed
        op_sum  = 2'd2                                          // Signed sum of all lanes
    } op_t;

    // ==================================================
    // Frame lock
    // ==================================================

    typedef enum logic {
        st_hunt   = 1'b0,                                       // Waiting for sync edge
        st_locked = 1'b1
    } lock_state_t;

endpackage

// File: rtl/quadc_result.sv
`timescale 1ns/1ns

module quadc_result #(
    parameter int fifo_depth = 16
) (
    input  logic                             adc0_clk,
    input  logic                             reset,
    input  logic                             exe_valid,
    input  logic [quadc_pkg::word_width-1:0] exe_word,
    input  logic                             exe_frame,
    input  logic                             rd_en,
    output logic [quadc_pkg::word_width-1:0] sample_word,
    output logic                             frame_start,
    output logic                             valid,
    output logic                             empty,
    output logic                             overflow
);

    import quadc_pkg::*;

    localparam int                addr_width = $clog2(fifo_depth);
    localparam logic [addr_width:0] full_count = (addr_width + 1)'(fifo_depth);

    logic [word_width:0]   mem [fifo_depth];            // Word with frame flag in bit 0
    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] rd_ptr;
    logic [addr_width:0]   count;
    logic                  full;
    logic                  do_write;
    logic                  do_read;

    assign full     = (count == full_count);
    assign empty    = (count == '0);
    assign do_write = exe_valid & ~full;                // Dropped when full
    assign do_read  = rd_en & ~empty;

    // ==================================================
    // Storage and pointers
    // ==================================================

    always_ff @(posedge adc0_clk) begin
        if (do_write)
            mem[wr_ptr] <= {exe_word, exe_frame};
    end

    always_ff @(posedge adc0_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;                // Wraps at power of two
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // Both or neither
            endcase
        end
    end

    // ==================================================
    // Host read side and status
    // ==================================================

    always_ff @(posedge adc0_clk) begin
        if (reset) begin
            valid    <= 1'b0;
            overflow <= 1'b0;
        end else begin
            valid <= do_read;                           // One cycle per pop
            if (exe_valid && full)
                overflow <= 1'b1;                       // Sticks until reset
        end
    end

    always_ff @(posedge adc0_clk) begin
        if (do_read)
            {sample_word, frame_start} <= mem[rd_ptr];
    end

    assert property (@(posedge adc0_clk) disable iff (reset)
        count <= full_count);

    // A pop is only ever taken from a filled buffer
    assert property (@(posedge adc0_clk) disable iff (reset)
        valid |-> !$past(empty));

endmodule

// File: rtl/quadc_top.sv
`timescale 1ns/1ns

module quadc_top #(
    parameter int fifo_depth = 16
) (
    input  logic                               adc0_clk,
    input  logic                               reset,
    input  logic [quadc_pkg::sample_width-1:0] adc0_data,
    input  logic [quadc_pkg::sample_width-1:0] adc1_data,
    input  logic [quadc_pkg::sample_width-1:0] adc2_data,
    input  logic [quadc_pkg::sample_width-1:0] adc3_data,
    input  logic                               sync_in,
    input  logic                               enable,
    input  quadc_pkg::mode_t                   mode,
    input  logic                               rd_en,
    output logic [quadc_pkg::word_width-1:0]   sample_word,
    output logic                               frame_start,
    output logic                               valid,
    output logic                               empty,
    output logic                               overflow
);

    import quadc_pkg::*;

    logic                  dec_valid;
    op_t                   dec_op;
    logic [word_width-1:0] dec_word;
    logic                  dec_frame;

    logic                  exe_valid;
    logic [word_width-1:0] exe_word;
    logic                  exe_frame;

    // ==================================================
    // Capture path
    // ==================================================

    quadc_decode quadc_decode_inst (
        .adc0_clk  (adc0_clk),
        .reset     (reset),
        .enable    (enable),
        .mode      (mode),
        .adc0_data (adc0_data),
        .adc1_data (adc1_data),
        .adc2_data (adc2_data),
        .adc3_data (adc3_data),
        .sync_in   (sync_in),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_word  (dec_word),
        .dec_frame (dec_frame)
    );

    quadc_execute quadc_execute_inst (
        .adc0_clk  (adc0_clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_word  (dec_word),
        .dec_frame (dec_frame),
        .exe_valid (exe_valid),
        .exe_word  (exe_word),
        .exe_frame (exe_frame)
    );

    quadc_result #(
        .fifo_depth (fifo_depth)
    ) quadc_result_inst (
        .adc0_clk    (adc0_clk),
        .reset       (reset),
        .exe_valid   (exe_valid),
        .exe_word    (exe_word),
        .exe_frame   (exe_frame),
        .rd_en       (rd_en),
        .sample_word (sample_word),
        .frame_start (frame_start),
        .valid       (valid),
        .empty       (empty),
        .overflow    (overflow)
    );

endmodule

// File: src.f
rtl/quadc_pkg.sv
rtl/quadc_decode.sv
rtl/quadc_execute.sv
rtl/quadc_result.sv
rtl/quadc_top.sv
verif/quadc_tb.sv

// File: verif/quadc_tb.sv
`timescale 1ns/1ns

module quadc_tb;

    import quadc_pkg::*;

    localparam int fifo_depth  = 16;
    localparam int drain_limit = 40;                          // Cycles allowed per drain
    localparam int cycle_limit = 40 + 40 + 70 + 40 + 70 + 40 + 200;  // Test budgets plus margin

    logic                    adc0_clk;
    logic                    reset;
    logic [sample_width-1:0] adc0_data;
    logic [sample_width-1:0] adc1_data;
    logic [sample_width-1:0] adc2_data;
    logic [sample_width-1:0] adc3_data;
    logic                    sync_in;
    logic                    enable;
    mode_t                   mode;
    logic                    rd_en;
    logic [word_width-1:0]   sample_word;
    logic                    frame_start;
    logic                    valid;
    logic                    empty;
    logic                    overflow;

    logic [word_width:0]     exp_q[$];                        // Expected word with frame flag
    logic [31:0]             lfsr_state = 32'h7051;
    logic                    model_locked = 1'b0;
    logic                    model_prev_sync = 1'b0;
    int                      error_count = 0;
    int                      rx_count = 0;
    int                      cycle_count = 0;

    quadc_top #(
        .fifo_depth (fifo_depth)
    ) quadc_top_inst (
        .adc0_clk    (adc0_clk),
        .reset       (reset),
        .adc0_data   (adc0_data),
        .adc1_data   (adc1_data),
        .adc2_data   (adc2_data),
        .adc3_data   (adc3_data),
        .sync_in     (sync_in),
        .enable      (enable),
        .mode        (mode),
        .rd_en       (rd_en),
        .sample_word (sample_word),
        .frame_start (frame_start),
        .valid       (valid),
        .empty       (empty),
        .overflow    (overflow)
    );

    initial adc0_clk = 1'b0;
    always #50 adc0_clk = ~adc0_clk;                          // 100 ns period

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);               // One step per bit
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    // Offset binary lane value as a signed number
    function automatic int lane_value(input logic [7:0] d);
        return int'(d) - 128;
    endfunction

    function automatic logic [31:0] expected_word(input mode_t md, input logic [7:0] d0,
                                                  input logic [7:0] d1, input logic [7:0] d2,
                                                  input logic [7:0] d3);
        int total;
        logic [31:0] w;
        w = {d0, d1, d2, d3};
        case (md)
            mode_twos: w = {8'(lane_value(d0)), 8'(lane_value(d1)),
                            8'(lane_value(d2)), 8'(lane_value(d3))};
            mode_sum: begin
                total = lane_value(d0) + lane_value(d1) + lane_value(d2) + lane_value(d3);
                w = 32'(total);
            end
            default: w = {d0, d1, d2, d3};                    // Raw and reserved
        endcase
        return w;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    // Drives one sample set and predicts whether decode emits it
    task automatic drive_set(input logic [7:0] d0, input logic [7:0] d1, input logic [7:0] d2,
                             input logic [7:0] d3, input logic sync, input logic en,
                             input mode_t md, input logic keep);
        logic is_edge;
        logic emitted;
        @(posedge adc0_clk);
        adc0_data <= d0;
        adc1_data <= d1;
        adc2_data <= d2;
        adc3_data <= d3;
        sync_in   <= sync;
        enable    <= en;
        mode      <= md;
        is_edge = sync && !model_prev_sync;
        emitted = en && (model_locked || is_edge);
        if (emitted && keep)
            exp_q.push_back({expected_word(md, d0, d1, d2, d3), is_edge});
        if (!model_locked && en && is_edge)
            model_locked = 1'b1;
        else if (model_locked && !en)
            model_locked = 1'b0;                              // Back to hunt
        model_prev_sync = sync;
    endtask

    task automatic drive_random(input logic sync, input logic en, input mode_t md,
                                input logic keep);
        logic [7:0] d0;
        logic [7:0] d1;
        logic [7:0] d2;
        logic [7:0] d3;
        random_byte(d0);
        random_byte(d1);
        random_byte(d2);
        random_byte(d3);
        drive_set(d0, d1, d2, d3, sync, en, md, keep);
    endtask

    task automatic drive_idle();
        drive_set(8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, mode_raw, 1'b0);
    endtask

    task automatic set_read(input logic level);
        @(posedge adc0_clk);
        rd_en <= level;
    endtask

    // Waits until every expected word was read, then a quiet window for strays
    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        drive_idle();
        while (exp_q.size() != 0 && waited < drain_limit) begin
            @(posedge adc0_clk);
            waited++;
        end
        repeat (6) @(posedge adc0_clk);
        @(negedge adc0_clk);
        if (exp_q.size() != 0 || !empty) begin
            $display("Error at %0t ns: %s did not drain, %0d words still missing",
                     $time, what, exp_q.size());
            error_count++;
        end
    endtask

    task automatic run_burst(input mode_t md, input int n, input string what);
        drive_random(1'b1, 1'b1, md, 1'b1);                   // Sync edge set
        for (int i = 1; i < n; i++)
            drive_random(1'b0, 1'b1, md, 1'b1);
        wait_drain(what);
    endtask

    // ==================================================
    // Tests
    // ==================================================

    task automatic test_reset_hunt();
        @(negedge adc0_clk);
        check_value(32'(valid), 32'd0, "valid after reset");
        check_value(32'(overflow), 32'd0, "overflow after reset");
        check_value(32'(empty), 32'd1, "empty after reset");
        set_read(1'b1);
        for (int i = 0; i < 20; i++)
            drive_random(1'b0, 1'b1, mode_raw, 1'b1);         // No sync, nothing emitted
        wait_drain("hunt test");
        check_value(32'(empty), 32'd1, "empty while hunting");
    endtask

    task automatic test_sum();
        drive_set(8'h00, 8'h00, 8'h00, 8'h00, 1'b1, 1'b1, mode_sum, 1'b0);
        exp_q.push_back({32'hFFFF_FE00, 1'b1});              // Low end of the range
        drive_set(8'hFF, 8'hFF, 8'hFF, 8'hFF, 1'b0, 1'b1, mode_sum, 1'b0);
        exp_q.push_back({32'd508, 1'b0});                    // High end of the range
        for (int i = 0; i < 10; i++)
            drive_random(1'b0, 1'b1, mode_sum, 1'b1);
        wait_drain("sum test");
    endtask

    task automatic test_overflow();
        int rx_start;
        set_read(1'b0);
        drive_random(1'b1, 1'b1, mode_raw, 1'b1);
        for (int i = 0; i < 23; i++)
            drive_random(1'b0, 1'b1, mode_raw, 1'(i < fifo_depth - 1));  // Only first 16 kept
        drive_idle();
        repeat (6) @(posedge adc0_clk);                       // Last word reaches the FIFO
        @(negedge adc0_clk);
        check_value(32'(overflow), 32'd1, "overflow after 24 sets");
        check_value(32'(empty), 32'd0, "empty with full FIFO");
        rx_start = rx_count;
        set_read(1'b1);
        wait_drain("overflow test");
        check_value(32'(rx_count - rx_start), 32'd16, "words read after overflow");
        check_value(32'(overflow), 32'd1, "overflow after drain");
        check_value(32'(empty), 32'd1, "empty after drain");
    endtask

    task automatic test_lock_loss();
        drive_random(1'b1, 1'b1, mode_raw, 1'b1);
        for (int i = 0; i < 5; i++)
            drive_random(1'b0, 1'b1, mode_raw, 1'b1);
        drive_random(1'b0, 1'b0, mode_raw, 1'b1);             // Enable low drops lock
        for (int i = 0; i < 5; i++)
            drive_random(1'b0, 1'b1, mode_raw, 1'b1);         // Hunting, not emitted
        drive_random(1'b1, 1'b1, mode_twos, 1'b1);            // Relock with frame flag
        for (int i = 0; i < 3; i++)
            drive_random(1'b0, 1'b1, mode_twos, 1'b1);
        wait_drain("lock loss test");
    endtask

    task automatic finish_run();
        $display("Run complete: %0d errors, %0d words read", error_count, rx_count);
        if (error_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    endtask

    // ==================================================
    // Output monitor and watchdog
    // ==================================================

    always @(negedge adc0_clk) begin : monitor
        logic [word_width:0] entry;
        if (!reset && valid) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t ns: valid pulse with no word expected, word %h",
                         $time, sample_word);
                error_count++;
            end else begin
                entry = exp_q.pop_front();
                check_value(sample_word, entry[word_width:1], "sample_word");
                check_value(32'(frame_start), 32'(entry[0]), "frame_start");
            end
            rx_count++;
        end
    end

    always @(posedge adc0_clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            error_count++;
            finish_run();
        end
    end

    initial begin
        adc0_data <= '0;
        adc1_data <= '0;
        adc2_data <= '0;
        adc3_data <= '0;
        sync_in   <= 1'b0;
        enable    <= 1'b0;
        mode      <= mode_raw;
        rd_en     <= 1'b0;
        reset     <= 1'b1;
        repeat (4) @(posedge adc0_clk);
        reset <= 1'b0;

        test_reset_hunt();
        run_burst(mode_raw, 16, "raw test");
        run_burst(mode_twos, 12, "two's complement test");
        run_burst(mode_reserved, 8, "reserved mode test");
        test_sum();
        test_overflow();
        test_lock_loss();
        finish_run();
    end

endmodule
